// File: src/asymfifo_pkg.sv
// ----------------------------------------------------------
// Shared widths and width ratio of the asymmetric FIFO
// Packed union for one RAM word and error state codes
// ----------------------------------------------------------
`default_nettype none

package asymfifo_pkg;

	// ----------------------------------------------------------
	// Widths
	// ----------------------------------------------------------

	// Write side sub-word
	localparam int IN_WIDTH = 8;
	// Stored and popped word
	localparam int OUT_WIDTH = 16;
	// Sub-words per stored word
	localparam int RATIO = OUT_WIDTH / IN_WIDTH;
	// Index into the sub view, never narrower than one bit
	localparam int SUB_IDX_WIDTH = (RATIO > 1) ? $clog2(RATIO) : 1;

	// ----------------------------------------------------------
	// RAM word
	// ----------------------------------------------------------

	// Packer fills sub, RAM and read side use full
	// sub[RATIO-1] sits at the most significant end
	typedef union packed {
		logic [OUT_WIDTH-1:0]               full;
		logic [RATIO-1:0][IN_WIDTH-1:0]     sub;
	} fifo_word_u;

	// ----------------------------------------------------------
	// Error state codes
	// ----------------------------------------------------------
	localparam logic ERR_OK  = 1'b0;
	localparam logic ERR_SET = 1'b1;

endpackage

`default_nettype wire

// File: src/asymfifo_ctl_fsm.sv
// ----------------------------------------------------------
// Request decode and error state machine
// Accepts or drops push, pop and flush, issues RAM writes
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asymfifo_ctl_fsm #(
	parameter int err_mode = 0
) (
	input  wire  clk,
	input  wire  arst_n,
	input  wire  push_req_n,
	input  wire  pop_req_n,
	input  wire  flush_n,
	input  wire  sub_last,
	input  wire  part_wd,
	input  wire  ram_full,
	input  wire  empty,
	output logic push_ok,
	output logic flush_ok,
	output logic pop_ok,
	output logic we,
	output logic full,
	output logic error
);
	import asymfifo_pkg::*;

	logic push_req;
	logic pop_req;
	logic flush_req;
	// Packer still holds a partial word once this cycle's push is in
	logic part_after;
	logic err_now;
	logic err_q;
	logic err_next;

	// Active-high versions of the strobes
	assign push_req  = ~push_req_n;
	assign pop_req   = ~pop_req_n;
	assign flush_req = ~flush_n;

	// No room for the sub-word that would complete a word
	assign full = ram_full & sub_last;

	// ----------------------------------------------------------
	// Request decode
	// ----------------------------------------------------------
	assign push_ok = push_req & ~full;
	assign pop_ok  = pop_req & ~empty;

	// Push goes first, flush then sees what is left
	assign part_after = (part_wd | push_ok) & ~(push_ok & sub_last);
	assign flush_ok   = flush_req & part_after & ~ram_full;

	// Completing push or accepted flush writes one word
	assign we = (push_ok & sub_last) | flush_ok;

	// Overflow, underflow, or flush with nowhere to go
	assign err_now = (push_req & full) |
		(pop_req & empty) |
		(flush_req & part_after & ram_full);

	// ----------------------------------------------------------
	// Error state
	// ----------------------------------------------------------
	always_comb begin
		if (err_mode == 0) begin
			// Sticky until reset
			err_next = ((err_q == ERR_SET) || err_now) ? ERR_SET : ERR_OK;
		end else begin
			// Only this cycle's fault
			err_next = err_now ? ERR_SET : ERR_OK;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			err_q <= ERR_OK;
		end else begin
			err_q <= err_next;
		end
	end

	assign error = (err_q == ERR_SET);

endmodule

`default_nettype wire

// File: src/asymfifo_word_count.sv
// ----------------------------------------------------------
// RAM pointers, word count and registered level flags
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asymfifo_word_count #(
	parameter int depth    = 8,
	parameter int ae_level = 2,
	parameter int af_level = 2,
	localparam int AW      = (depth > 1) ? $clog2(depth) : 1
) (
	input  wire           clk,
	input  wire           arst_n,
	input  wire           we,
	input  wire           pop_ok,
	output logic [AW-1:0] wr_addr,
	output logic [AW-1:0] rd_addr,
	output logic          empty,
	output logic          almost_empty,
	output logic          half_full,
	output logic          almost_full,
	output logic          ram_full
);

	// Count runs 0..depth inclusive
	localparam int CW = $clog2(depth + 1);
	localparam logic [AW-1:0] LAST_ADDR = AW'(depth - 1);

	logic [CW-1:0] count_q;
	logic [CW-1:0] count_next;

	// ----------------------------------------------------------
	// Next count
	// ----------------------------------------------------------
	always_comb begin
		case ({we, pop_ok})
			2'b10:   count_next = count_q + CW'(1);
			2'b01:   count_next = count_q - CW'(1);
			// Write with pop leaves the level as it is
			default: count_next = count_q;
		endcase
	end

	// ----------------------------------------------------------
	// Pointers and count
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_addr <= '0;
			rd_addr <= '0;
			count_q <= '0;
		end else begin
			// Wrap at the last RAM entry, depth need not be a power of two
			if (we) begin
				wr_addr <= (wr_addr == LAST_ADDR) ? '0 : wr_addr + AW'(1);
			end
			if (pop_ok) begin
				rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + AW'(1);
			end
			count_q <= count_next;
		end
	end

	// ----------------------------------------------------------
	// Level flags, registered from the next count
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Empty RAM after reset
			empty        <= 1'b1;
			almost_empty <= 1'b1;
			half_full    <= 1'b0;
			almost_full  <= 1'b0;
			ram_full     <= 1'b0;
		end else begin
			empty        <= (count_next == '0);
			almost_empty <= (count_next <= CW'(ae_level));
			// Rounds up for odd depth
			half_full    <= (count_next >= CW'((depth + 1) / 2));
			almost_full  <= (count_next >= CW'(depth - af_level));
			ram_full     <= (count_next == CW'(depth));
		end
	end

endmodule

`default_nettype wire

// File: src/asymfifo_in_pack.sv
// ----------------------------------------------------------
// Sub-word packer
// Builds RAM words from narrow pushes, reports partial word
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asymfifo_in_pack #(
	parameter int byte_order = 0
) (
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire                              push_ok,
	input  wire                              flush_ok,
	input  wire [asymfifo_pkg::IN_WIDTH-1:0] data_in,
	output asymfifo_pkg::fifo_word_u         wr_word,
	output logic                             sub_last,
	output logic                             part_wd
);
	import asymfifo_pkg::*;

	localparam logic [SUB_IDX_WIDTH-1:0] LAST_IDX = SUB_IDX_WIDTH'(RATIO - 1);

	// Sub-words already held
	logic [SUB_IDX_WIDTH-1:0] idx_q;
	// Slot in the sub view for the incoming sub-word
	logic [SUB_IDX_WIDTH-1:0] slot;
	fifo_word_u               hold_q;

	// Order 0 fills from the top slot down, order 1 from slot 0 up
	assign slot = (byte_order == 1) ? idx_q : LAST_IDX - idx_q;

	// Next sub-word closes the word
	assign sub_last = (idx_q == LAST_IDX);
	assign part_wd  = (idx_q != '0);

	// ----------------------------------------------------------
	// Word seen by the RAM this cycle
	// ----------------------------------------------------------
	always_comb begin
		wr_word = hold_q;
		if (push_ok) begin
			wr_word.sub[slot] = data_in;
		end
	end

	// ----------------------------------------------------------
	// Holding word and index
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			idx_q  <= '0;
			hold_q <= '0;
		end else if (flush_ok || (push_ok && sub_last)) begin
			// Word leaves for the RAM, start clean so unfilled slots read zero
			idx_q  <= '0;
			hold_q <= '0;
		end else if (push_ok) begin
			idx_q  <= idx_q + SUB_IDX_WIDTH'(1);
			hold_q <= wr_word;
		end
	end

endmodule

`default_nettype wire

// File: src/asymfifo_ram.sv
// ----------------------------------------------------------
// Flip-flop RAM, synchronous write, asynchronous read
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asymfifo_ram #(
	parameter int depth = 8,
	localparam int AW   = (depth > 1) ? $clog2(depth) : 1
) (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       we,
	input  wire [AW-1:0]              wr_addr,
	input  wire [AW-1:0]              rd_addr,
	input  asymfifo_pkg::fifo_word_u  wr_word,
	output asymfifo_pkg::fifo_word_u  rd_word
);
	import asymfifo_pkg::*;

	// Storage array
	fifo_word_u mem [depth];

	// ----------------------------------------------------------
	// Write port
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_addr] <= wr_word;
		end
	end

	// Read port, no clock
	assign rd_word = mem[rd_addr];

endmodule

`default_nettype wire

// File: src/asymfifo_s1_sf.sv
// ----------------------------------------------------------
// Single-clock asymmetric FIFO top level
// Control FSM, counter, packer and RAM
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asymfifo_s1_sf #(
	parameter int depth      = 8,
	parameter int ae_level   = 2,
	parameter int af_level   = 2,
	parameter int err_mode   = 0,
	parameter int byte_order = 0
) (
	input  wire                               clk,
	input  wire                               arst_n,
	input  wire                               push_req_n,
	input  wire                               pop_req_n,
	input  wire                               flush_n,
	input  wire [asymfifo_pkg::IN_WIDTH-1:0]  data_in,
	output logic [asymfifo_pkg::OUT_WIDTH-1:0] data_out,
	output logic                              empty,
	output logic                              almost_empty,
	output logic                              half_full,
	output logic                              almost_full,
	output logic                              full,
	output logic                              ram_full,
	output logic                              part_wd,
	output logic                              error
);
	import asymfifo_pkg::*;

	localparam int AW = (depth > 1) ? $clog2(depth) : 1;

	// FSM strobes
	logic push_ok;
	logic flush_ok;
	logic pop_ok;
	logic we;
	// Packer status
	logic sub_last;
	// RAM side
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;
	fifo_word_u    wr_word;
	fifo_word_u    rd_word;

	// ----------------------------------------------------------
	// Request decode and error
	// ----------------------------------------------------------
	asymfifo_ctl_fsm #(
		.err_mode (err_mode)
	) u_ctl_fsm (
		.clk        (clk),
		.arst_n     (arst_n),
		.push_req_n (push_req_n),
		.pop_req_n  (pop_req_n),
		.flush_n    (flush_n),
		.sub_last   (sub_last),
		.part_wd    (part_wd),
		.ram_full   (ram_full),
		.empty      (empty),
		.push_ok    (push_ok),
		.flush_ok   (flush_ok),
		.pop_ok     (pop_ok),
		.we         (we),
		.full       (full),
		.error      (error)
	);

	// Pointers and flags
	asymfifo_word_count #(
		.depth    (depth),
		.ae_level (ae_level),
		.af_level (af_level)
	) u_word_count (
		.clk          (clk),
		.arst_n       (arst_n),
		.we           (we),
		.pop_ok       (pop_ok),
		.wr_addr      (wr_addr),
		.rd_addr      (rd_addr),
		.empty        (empty),
		.almost_empty (almost_empty),
		.half_full    (half_full),
		.almost_full  (almost_full),
		.ram_full     (ram_full)
	);

	// Sub-words in, full words out
	asymfifo_in_pack #(
		.byte_order (byte_order)
	) u_in_pack (
		.clk      (clk),
		.arst_n   (arst_n),
		.push_ok  (push_ok),
		.flush_ok (flush_ok),
		.data_in  (data_in),
		.wr_word  (wr_word),
		.sub_last (sub_last),
		.part_wd  (part_wd)
	);

	// ----------------------------------------------------------
	// Storage
	// ----------------------------------------------------------
	asymfifo_ram #(
		.depth (depth)
	) u_ram (
		.clk     (clk),
		.arst_n  (arst_n),
		.we      (we),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr),
		.wr_word (wr_word),
		.rd_word (rd_word)
	);

	// Read side sees the whole word
	assign data_out = rd_word.full;

endmodule

`default_nettype wire

// File: tests/tb_asymfifo_model.svh
// ----------------------------------------------------------
// Reference model for the asymmetric FIFO testbench
// Expected word queue, packing and level flag functions
// ----------------------------------------------------------
`ifndef TB_ASYMFIFO_MODEL_SVH
`define TB_ASYMFIFO_MODEL_SVH

// Words expected in the RAM, oldest first
logic [OUT_WIDTH-1:0] exp_words[$];
// Sub-words of the word under construction
logic [IN_WIDTH-1:0]  held_subs[$];
bit                   exp_error;

// Sub-words in arrival order, unfilled slots stay zero
function automatic logic [OUT_WIDTH-1:0] pack_word(
	input logic [IN_WIDTH-1:0] subs[$],
	input int                  order
);
	logic [OUT_WIDTH-1:0] word;
	int                   pos;
	word = '0;
	for (int i = 0; i < subs.size(); i++) begin
		// Order 0 puts the first arrival at the top
		pos  = (order == 1) ? i : RATIO - 1 - i;
		word = word | (OUT_WIDTH'(subs[i]) << (pos * IN_WIDTH));
	end
	return word;
endfunction

// {empty, almost_empty, half_full, almost_full, ram_full, full}
function automatic logic [5:0] level_flags(input int count, input int held);
	logic [5:0] f;
	f[5] = (count == 0);
	f[4] = (count <= ae_level);
	f[3] = (2 * count >= depth);
	f[2] = (count >= depth - af_level);
	f[1] = (count == depth);
	// No slot left for a word that would complete
	f[0] = (count == depth) && (held == RATIO - 1);
	return f;
endfunction

task automatic clear_model();
	exp_words.delete();
	held_subs.delete();
	exp_error = 1'b0;
endtask

// One rising edge, acceptance decided on the pre-edge state
task automatic update_model(
	input bit                  push,
	input bit                  pop,
	input bit                  flush,
	input logic [IN_WIDTH-1:0] din
);
	int                   count;
	bit                   was_ram_full;
	bit                   was_full;
	bit                   fault;
	count        = exp_words.size();
	was_ram_full = (count == depth);
	was_full     = was_ram_full && (held_subs.size() == RATIO - 1);
	fault        = 1'b0;
	if (pop) begin
		if (count == 0) begin
			fault = 1'b1;
		end else begin
			exp_words.delete(0);
		end
	end
	if (push) begin
		if (was_full) begin
			fault = 1'b1;
		end else begin
			held_subs.push_back(din);
			if (held_subs.size() == RATIO) begin
				exp_words.push_back(pack_word(held_subs, byte_order));
				held_subs.delete();
			end
		end
	end
	// Flush closes what the push left behind
	if (flush && (held_subs.size() != 0)) begin
		if (was_ram_full) begin
			fault = 1'b1;
		end else begin
			exp_words.push_back(pack_word(held_subs, byte_order));
			held_subs.delete();
		end
	end
	if (err_mode == 0) begin
		exp_error = exp_error | fault;
	end else begin
		exp_error = fault;
	end
endtask

`endif

// File: tests/tb_asymfifo.sv
// ----------------------------------------------------------
// Testbench for the single-clock asymmetric FIFO
// Clock, reset, directed and random stimulus
// Per-cycle comparison against the reference model
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_asymfifo;
	import asymfifo_pkg::*;

	localparam int depth      = 8;
	localparam int ae_level   = 2;
	localparam int af_level   = 2;
	localparam int err_mode   = 0;
	localparam int byte_order = 0;
	// Bound for every wait loop, in cycles
	localparam int step_limit = 64;
	localparam int run_limit  = 20000;

	logic                 clk = 1'b0;
	logic                 arst_n;
	logic                 push_req_n;
	logic                 pop_req_n;
	logic                 flush_n;
	logic [IN_WIDTH-1:0]  data_in;
	logic [OUT_WIDTH-1:0] data_out;
	logic                 empty;
	logic                 almost_empty;
	logic                 half_full;
	logic                 almost_full;
	logic                 full;
	logic                 ram_full;
	logic                 part_wd;
	logic                 error;
	string                test_name;

	`include "tb_asymfifo_model.svh"

	asymfifo_s1_sf #(
		.depth      (depth),
		.ae_level   (ae_level),
		.af_level   (af_level),
		.err_mode   (err_mode),
		.byte_order (byte_order)
	) u_dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.push_req_n   (push_req_n),
		.pop_req_n    (pop_req_n),
		.flush_n      (flush_n),
		.data_in      (data_in),
		.data_out     (data_out),
		.empty        (empty),
		.almost_empty (almost_empty),
		.half_full    (half_full),
		.almost_full  (almost_full),
		.full         (full),
		.ram_full     (ram_full),
		.part_wd      (part_wd),
		.error        (error)
	);

	// 40 ns clock
	initial begin
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------
	// Reporting
	// ----------------------------------------------------------
	task automatic fail_stop(input string reason);
		$display("ERROR in test %s: %s", test_name, reason);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(
		input string       item,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		assert (actual === expected) else begin
			$display("CHECK FAILED test=%s %s expected=%0h actual=%0h",
				test_name, item, expected, actual);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// ----------------------------------------------------------
	// Stimulus helpers, called on a falling edge
	// ----------------------------------------------------------
	task automatic set_idle();
		push_req_n = 1'b1;
		pop_req_n  = 1'b1;
		flush_n    = 1'b1;
		data_in    = '0;
	endtask

	// Hold one request set across the next rising edge
	task automatic drive_cycle(
		input bit                  push,
		input bit                  pop,
		input bit                  flush,
		input logic [IN_WIDTH-1:0] d
	);
		push_req_n = ~push;
		pop_req_n  = ~pop;
		flush_n    = ~flush;
		data_in    = d;
		@(negedge clk);
	endtask

	task automatic idle_cycles(input int n);
		set_idle();
		repeat (n) @(negedge clk);
	endtask

	task automatic apply_reset();
		set_idle();
		arst_n = 1'b0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
	endtask

	// Push sub-words until the RAM reports full
	task automatic fill_ram();
		int steps;
		steps = 0;
		while (!ram_full && (steps < step_limit)) begin
			drive_cycle(1'b1, 1'b0, 1'b0, IN_WIDTH'($urandom));
			steps++;
		end
		set_idle();
		if (!ram_full) begin
			fail_stop("ram_full never rose while filling");
		end
	endtask

	task automatic drain_fifo(output int popped);
		popped = 0;
		while (!empty && (popped < step_limit)) begin
			drive_cycle(1'b0, 1'b1, 1'b0, '0);
			popped++;
		end
		set_idle();
		if (!empty) begin
			fail_stop("empty never rose while draining");
		end
	endtask

	// ----------------------------------------------------------
	// Per-cycle comparison with the model
	// ----------------------------------------------------------
	initial begin : compare_outputs
		logic [5:0] f;
		forever begin
			@(posedge clk);
			if (!arst_n) begin
				clear_model();
			end else begin
				update_model(!push_req_n, !pop_req_n, !flush_n, data_in);
			end
			// Let registered outputs settle
			#1;
			f = level_flags(exp_words.size(), held_subs.size());
			check_value("empty", 32'(f[5]), 32'(empty));
			check_value("almost_empty", 32'(f[4]), 32'(almost_empty));
			check_value("half_full", 32'(f[3]), 32'(half_full));
			check_value("almost_full", 32'(f[2]), 32'(almost_full));
			check_value("ram_full", 32'(f[1]), 32'(ram_full));
			check_value("full", 32'(f[0]), 32'(full));
			check_value("part_wd", 32'(held_subs.size() != 0), 32'(part_wd));
			check_value("error", 32'(exp_error), 32'(error));
			if (!empty && (exp_words.size() != 0)) begin
				check_value("data_out", 32'(exp_words[0]), 32'(data_out));
			end
		end
	end

	// Hard stop for a run that never ends
	initial begin : watchdog
		repeat (run_limit) @(posedge clk);
		fail_stop("run exceeded the cycle limit");
	end

	// ----------------------------------------------------------
	// Test sequences
	// ----------------------------------------------------------
	task automatic check_reset_state();
		check_value("empty", 32'd1, 32'(empty));
		check_value("almost_empty", 32'd1, 32'(almost_empty));
		check_value("half_full", 32'd0, 32'(half_full));
		check_value("almost_full", 32'd0, 32'(almost_full));
		check_value("full", 32'd0, 32'(full));
		check_value("ram_full", 32'd0, 32'(ram_full));
		check_value("part_wd", 32'd0, 32'(part_wd));
		check_value("error", 32'd0, 32'(error));
	endtask

	task automatic pack_pairs(input int pairs);
		logic [IN_WIDTH-1:0]  subs[$];
		logic [OUT_WIDTH-1:0] sent[$];
		logic [IN_WIDTH-1:0]  b;
		for (int k = 0; k < pairs; k++) begin
			subs.delete();
			b = IN_WIDTH'($urandom);
			subs.push_back(b);
			drive_cycle(1'b1, 1'b0, 1'b0, b);
			// Half a word held
			check_value("part_wd mid pair", 32'd1, 32'(part_wd));
			b = IN_WIDTH'($urandom);
			subs.push_back(b);
			drive_cycle(1'b1, 1'b0, 1'b0, b);
			check_value("part_wd after pair", 32'd0, 32'(part_wd));
			sent.push_back(pack_word(subs, byte_order));
		end
		set_idle();
		foreach (sent[k]) begin
			check_value("popped word", 32'(sent[k]), 32'(data_out));
			drive_cycle(1'b0, 1'b1, 1'b0, '0);
		end
		set_idle();
		check_value("empty after pops", 32'd1, 32'(empty));
	endtask

	task automatic sweep_levels();
		int popped;
		fill_ram();
		check_value("full with no partial", 32'd0, 32'(full));
		// One sub-word fits in the packer
		drive_cycle(1'b1, 1'b0, 1'b0, IN_WIDTH'($urandom));
		check_value("full with partial", 32'd1, 32'(full));
		drive_cycle(1'b0, 1'b1, 1'b0, '0);
		check_value("full after pop", 32'd0, 32'(full));
		drive_cycle(1'b1, 1'b0, 1'b0, IN_WIDTH'($urandom));
		check_value("ram_full refilled", 32'd1, 32'(ram_full));
		drain_fifo(popped);
		check_value("words drained", 32'(depth), 32'(popped));
	endtask

	task automatic flush_partial();
		logic [IN_WIDTH-1:0] subs[$];
		logic [IN_WIDTH-1:0] b;
		int                  popped;
		b = IN_WIDTH'($urandom);
		subs.push_back(b);
		drive_cycle(1'b1, 1'b0, 1'b0, b);
		check_value("part_wd before flush", 32'd1, 32'(part_wd));
		drive_cycle(1'b0, 1'b0, 1'b1, '0);
		check_value("part_wd after flush", 32'd0, 32'(part_wd));
		check_value("flushed word", 32'(pack_word(subs, byte_order)), 32'(data_out));
		// Nothing held, so nothing happens
		drive_cycle(1'b0, 1'b0, 1'b1, '0);
		check_value("empty flush error", 32'd0, 32'(error));
		// Only the flushed word was stored
		drive_cycle(1'b0, 1'b1, 1'b0, '0);
		check_value("empty flush level", 32'd1, 32'(empty));
		// Push and flush together
		subs.delete();
		b = IN_WIDTH'($urandom);
		subs.push_back(b);
		drive_cycle(1'b1, 1'b0, 1'b1, b);
		check_value("part_wd push flush", 32'd0, 32'(part_wd));
		check_value("push flush word", 32'(pack_word(subs, byte_order)), 32'(data_out));
		drain_fifo(popped);
		check_value("push flush count", 32'd1, 32'(popped));
		check_value("flush error", 32'd0, 32'(error));
	endtask

	task automatic random_traffic(input int cycles, input int push_pct, input int pop_pct);
		for (int i = 0; i < cycles; i++) begin
			drive_cycle($urandom_range(99) < push_pct, $urandom_range(99) < pop_pct,
				$urandom_range(99) < 10, IN_WIDTH'($urandom));
		end
		set_idle();
	endtask

	task automatic underflow_sticky();
		check_value("error before pop", 32'd0, 32'(error));
		drive_cycle(1'b0, 1'b1, 1'b0, '0);
		check_value("error on underflow", 32'd1, 32'(error));
		check_value("empty on underflow", 32'd1, 32'(empty));
		idle_cycles(3);
		if (err_mode == 0) begin
			check_value("sticky error", 32'd1, 32'(error));
		end
	endtask

	task automatic overflow_drop();
		int popped;
		fill_ram();
		drive_cycle(1'b1, 1'b0, 1'b0, IN_WIDTH'($urandom));
		check_value("full before overflow", 32'd1, 32'(full));
		check_value("error before overflow", 32'd0, 32'(error));
		// Dropped sub-word
		drive_cycle(1'b1, 1'b0, 1'b0, IN_WIDTH'($urandom));
		check_value("error on overflow", 32'd1, 32'(error));
		check_value("part_wd on overflow", 32'd1, 32'(part_wd));
		drain_fifo(popped);
		check_value("words kept", 32'(depth), 32'(popped));
		if (err_mode == 0) begin
			check_value("sticky error", 32'd1, 32'(error));
		end
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial begin : main_sequence
		int popped;
		void'($urandom(32'h28ff3082));
		test_name = "reset";
		apply_reset();
		check_reset_state();
		test_name = "packing";
		pack_pairs(4);
		test_name = "levels";
		sweep_levels();
		test_name = "flush";
		flush_partial();
		test_name = "random";
		// Fill-heavy phase, then drain-heavy
		random_traffic(300, 60, 40);
		random_traffic(200, 35, 65);
		drain_fifo(popped);
		test_name = "underflow";
		apply_reset();
		underflow_sticky();
		test_name = "overflow";
		apply_reset();
		overflow_drop();
		idle_cycles(2);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
src/asymfifo_pkg.sv
src/asymfifo_ctl_fsm.sv
src/asymfifo_word_count.sv
src/asymfifo_in_pack.sv
src/asymfifo_ram.sv
src/asymfifo_s1_sf.sv
tests/tb_asymfifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the asymmetric FIFO testbench with Verilator and run it.
# The exit status is the simulator's: nonzero on any failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_asymfifo \
	-f vlog.f

./obj_dir/Vtb_asymfifo
